// File: include/dispatch_macros.svh
`ifndef DISPATCH_MACROS_SVH
`define DISPATCH_MACROS_SVH

// Register file sizes
`define ARCH_REGS 32
`define PHYS_REGS 48
// Physical registers not mapped by the committed state
`define FREE_LIST_SZ 16

// Queue depths
`define ROB_SZ 8
`define RS_SZ 4

// RV32 major opcodes that the decoder accepts
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_STORE 7'b0100011

`endif

// File: rtl/dispatch_pkg.sv
`default_nettype none
`include "dispatch_macros.svh"

package dispatch_pkg;

    // Architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] areg_t;
    // Physical register tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] preg_t;
    // Reorder buffer slot
    typedef logic [$clog2(`ROB_SZ)-1:0] rob_idx_t;
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;

    // Functional unit class
    typedef enum logic {
        ALU,
        STORE
    } fu_type_t;

    // Reservation station entry state
    typedef enum logic {
        RS_EMPTY,
        RS_WAIT
    } rs_state_t;

endpackage

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module decoder (
    input wire dispatch_pkg::inst_t inst,
    output dispatch_pkg::fu_type_t fu_type,
    output logic uses_rs1,
    output logic uses_rs2,
    output logic has_dest,
    output logic illegal
);

    always_comb begin
        // Defaults describe an illegal instruction
        fu_type = dispatch_pkg::ALU;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        has_dest = 1'b0;
        illegal = 1'b1;
        case (inst[6:0])
            // Register-register ALU op
            `OPC_OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                has_dest = 1'b1;
                illegal = 1'b0;
            end
            // Immediate ALU op, rs2 field is part of the immediate
            `OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                has_dest = 1'b1;
                illegal = 1'b0;
            end
            // Store reads base and data, writes no register
            `OPC_STORE: begin
                fu_type = dispatch_pkg::STORE;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                illegal = 1'b0;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/map_table.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module map_table (
    input wire logic clock,
    input wire logic rst_n,
    input wire dispatch_pkg::areg_t src1_areg,
    input wire dispatch_pkg::areg_t src2_areg,
    input wire dispatch_pkg::areg_t dest_areg,
    input wire logic rename_en,
    input wire dispatch_pkg::preg_t new_preg,
    input wire logic commit_en,
    input wire dispatch_pkg::areg_t commit_areg,
    input wire dispatch_pkg::preg_t commit_preg,
    input wire logic cdb_valid,
    input wire dispatch_pkg::preg_t cdb_tag,
    input wire logic rollback,
    output dispatch_pkg::preg_t src1_preg,
    output dispatch_pkg::preg_t src2_preg,
    output logic src1_ready,
    output logic src2_ready,
    output dispatch_pkg::preg_t old_preg
);

    // Speculative and committed maps
    dispatch_pkg::preg_t spec_map [`ARCH_REGS];
    dispatch_pkg::preg_t arch_map [`ARCH_REGS];
    // One ready bit per physical register
    logic [`PHYS_REGS-1:0] ready;

    // x0 is hardwired to tag 0
    assign src1_preg = (src1_areg == '0) ? '0 : spec_map[src1_areg];
    assign src2_preg = (src2_areg == '0) ? '0 : spec_map[src2_areg];

    // Broadcast in this cycle counts as ready
    assign src1_ready = (src1_areg == '0) || ready[src1_preg]
                        || (cdb_valid && (cdb_tag == src1_preg));
    assign src2_ready = (src2_areg == '0) || ready[src2_preg]
                        || (cdb_valid && (cdb_tag == src2_preg));

    // Mapping replaced by a rename, goes to the ROB
    assign old_preg = spec_map[dest_areg];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Identity map, everything ready
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= dispatch_pkg::preg_t'(i);
                arch_map[i] <= dispatch_pkg::preg_t'(i);
            end
            ready <= '1;
        end else if (rollback) begin
            // Back to the committed state
            for (int i = 0; i < `ARCH_REGS; i++) begin
                spec_map[i] <= arch_map[i];
            end
            ready <= '1;
        end else begin
            if (commit_en) begin
                arch_map[commit_areg] <= commit_preg;
            end
            if (cdb_valid) begin
                ready[cdb_tag] <= 1'b1;
            end
            // New tag waits for its producer
            if (rename_en) begin
                spec_map[dest_areg] <= new_preg;
                ready[new_preg] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/free_list.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module free_list (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic dequeue_en,
    input wire logic enqueue_en,
    input wire dispatch_pkg::preg_t enqueue_preg,
    input wire logic rollback,
    output dispatch_pkg::preg_t head_preg,
    output logic empty
);

    localparam int IDX_W = $clog2(`FREE_LIST_SZ);

    dispatch_pkg::preg_t entries [`FREE_LIST_SZ];
    // Pointers carry an extra wrap bit
    logic [IDX_W:0] head_ptr;
    logic [IDX_W:0] tail_ptr;

    assign empty = (head_ptr == tail_ptr);
    assign head_preg = entries[head_ptr[IDX_W-1:0]];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Starts full with the tags above the architectural ones
            for (int i = 0; i < `FREE_LIST_SZ; i++) begin
                entries[i] <= dispatch_pkg::preg_t'(`ARCH_REGS + i);
            end
            head_ptr <= '0;
            tail_ptr <= {1'b1, {IDX_W{1'b0}}};
        end else if (rollback) begin
            // Slots between tail and head still hold the dequeued tags
            head_ptr <= {~tail_ptr[IDX_W], tail_ptr[IDX_W-1:0]};
        end else begin
            if (dequeue_en) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (enqueue_en) begin
                entries[tail_ptr[IDX_W-1:0]] <= enqueue_preg;
                tail_ptr <= tail_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module reorder_buffer (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic write_en,
    input wire dispatch_pkg::areg_t write_areg,
    input wire logic write_has_dest,
    input wire dispatch_pkg::preg_t write_new_preg,
    input wire dispatch_pkg::preg_t write_old_preg,
    input wire logic retire,
    input wire logic rollback,
    output dispatch_pkg::rob_idx_t tail_idx,
    output dispatch_pkg::rob_idx_t head_idx,
    output logic full,
    output logic empty,
    output logic commit_en,
    output dispatch_pkg::areg_t commit_areg,
    output dispatch_pkg::preg_t commit_new_preg,
    output dispatch_pkg::preg_t commit_old_preg
);

    localparam int CNT_W = $clog2(`ROB_SZ + 1);

    // Entry payload
    dispatch_pkg::areg_t areg [`ROB_SZ];
    logic has_dest [`ROB_SZ];
    dispatch_pkg::preg_t new_preg [`ROB_SZ];
    dispatch_pkg::preg_t old_preg [`ROB_SZ];

    logic [CNT_W-1:0] count;
    logic do_retire;

    assign full = (count == CNT_W'(`ROB_SZ));
    assign empty = (count == '0);

    // Retire on an empty queue or under rollback is dropped
    assign do_retire = retire && !empty && !rollback;

    // Head entry drives the commit
    assign commit_en = do_retire && has_dest[head_idx];
    assign commit_areg = areg[head_idx];
    assign commit_new_preg = new_preg[head_idx];
    assign commit_old_preg = old_preg[head_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_idx <= '0;
            tail_idx <= '0;
            count <= '0;
        end else if (rollback) begin
            head_idx <= '0;
            tail_idx <= '0;
            count <= '0;
        end else begin
            if (do_retire) begin
                head_idx <= head_idx + 1'b1;
            end
            if (write_en) begin
                tail_idx <= tail_idx + 1'b1;
            end
            count <= count + CNT_W'(write_en) - CNT_W'(do_retire);
        end
    end

    // Payload write, no reset
    always_ff @(posedge clock) begin
        if (write_en && !rollback) begin
            areg[tail_idx] <= write_areg;
            has_dest[tail_idx] <= write_has_dest;
            new_preg[tail_idx] <= write_new_preg;
            old_preg[tail_idx] <= write_old_preg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module reservation_station (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic alloc_en,
    input wire dispatch_pkg::fu_type_t alloc_fu,
    input wire dispatch_pkg::inst_t alloc_inst,
    input wire dispatch_pkg::addr_t alloc_pc,
    input wire dispatch_pkg::preg_t alloc_src1,
    input wire dispatch_pkg::preg_t alloc_src2,
    input wire dispatch_pkg::preg_t alloc_dest,
    input wire logic alloc_src1_ready,
    input wire logic alloc_src2_ready,
    input wire dispatch_pkg::rob_idx_t alloc_rob_idx,
    input wire logic cdb_valid,
    input wire dispatch_pkg::preg_t cdb_tag,
    input wire logic rollback,
    output logic full,
    output logic issue_valid,
    output dispatch_pkg::fu_type_t issue_fu,
    output dispatch_pkg::inst_t issue_inst,
    output dispatch_pkg::addr_t issue_pc,
    output dispatch_pkg::preg_t issue_src1,
    output dispatch_pkg::preg_t issue_src2,
    output dispatch_pkg::preg_t issue_dest,
    output dispatch_pkg::rob_idx_t issue_rob_idx
);

    localparam int IDX_W = $clog2(`RS_SZ);

    dispatch_pkg::rs_state_t state [`RS_SZ];
    // Entry payload
    dispatch_pkg::fu_type_t fu [`RS_SZ];
    dispatch_pkg::inst_t inst [`RS_SZ];
    dispatch_pkg::addr_t pc [`RS_SZ];
    dispatch_pkg::preg_t src1 [`RS_SZ];
    dispatch_pkg::preg_t src2 [`RS_SZ];
    dispatch_pkg::preg_t dest [`RS_SZ];
    dispatch_pkg::rob_idx_t rob_idx [`RS_SZ];
    logic src1_rdy [`RS_SZ];
    logic src2_rdy [`RS_SZ];

    logic [IDX_W-1:0] alloc_slot;
    logic alloc_found;
    logic [IDX_W-1:0] issue_slot;
    logic issue_found;

    // Lowest empty slot and lowest ready slot, scanned downward
    always_comb begin
        alloc_slot = '0;
        alloc_found = 1'b0;
        issue_slot = '0;
        issue_found = 1'b0;
        for (int i = `RS_SZ - 1; i >= 0; i--) begin
            if (state[i] == dispatch_pkg::RS_EMPTY) begin
                alloc_slot = IDX_W'(i);
                alloc_found = 1'b1;
            end
            if (state[i] == dispatch_pkg::RS_WAIT && src1_rdy[i] && src2_rdy[i]) begin
                issue_slot = IDX_W'(i);
                issue_found = 1'b1;
            end
        end
    end

    assign full = !alloc_found;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                state[i] <= dispatch_pkg::RS_EMPTY;
            end
            issue_valid <= 1'b0;
        end else if (rollback) begin
            // Flush everything waiting
            for (int i = 0; i < `RS_SZ; i++) begin
                state[i] <= dispatch_pkg::RS_EMPTY;
            end
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_found;
            if (issue_found) begin
                state[issue_slot] <= dispatch_pkg::RS_EMPTY;
            end
            if (alloc_en && alloc_found) begin
                state[alloc_slot] <= dispatch_pkg::RS_WAIT;
            end
        end
    end

    // Payload, wakeup and issue registers
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SZ; i++) begin
            if (cdb_valid && src1[i] == cdb_tag) src1_rdy[i] <= 1'b1;
            if (cdb_valid && src2[i] == cdb_tag) src2_rdy[i] <= 1'b1;
        end
        if (alloc_en && alloc_found) begin
            fu[alloc_slot] <= alloc_fu;
            inst[alloc_slot] <= alloc_inst;
            pc[alloc_slot] <= alloc_pc;
            src1[alloc_slot] <= alloc_src1;
            src2[alloc_slot] <= alloc_src2;
            dest[alloc_slot] <= alloc_dest;
            rob_idx[alloc_slot] <= alloc_rob_idx;
            src1_rdy[alloc_slot] <= alloc_src1_ready;
            src2_rdy[alloc_slot] <= alloc_src2_ready;
        end
        issue_fu <= fu[issue_slot];
        issue_inst <= inst[issue_slot];
        issue_pc <= pc[issue_slot];
        issue_src1 <= src1[issue_slot];
        issue_src2 <= src2[issue_slot];
        issue_dest <= dest[issue_slot];
        issue_rob_idx <= rob_idx[issue_slot];
    end

endmodule

`default_nettype wire

// File: rtl/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic inst_valid,
    input wire dispatch_pkg::inst_t inst,
    input wire dispatch_pkg::addr_t pc,
    input wire logic cdb_valid,
    input wire dispatch_pkg::preg_t cdb_tag,
    input wire logic retire,
    input wire logic rollback,
    output logic stall,
    output logic issue_valid,
    output dispatch_pkg::fu_type_t issue_fu,
    output dispatch_pkg::inst_t issue_inst,
    output dispatch_pkg::addr_t issue_pc,
    output dispatch_pkg::preg_t issue_src1,
    output dispatch_pkg::preg_t issue_src2,
    output dispatch_pkg::preg_t issue_dest,
    output dispatch_pkg::rob_idx_t issue_rob_idx,
    output dispatch_pkg::rob_idx_t rob_head_idx,
    output logic rob_empty,
    output logic rob_full
);

    // Decode results
    dispatch_pkg::fu_type_t fu_type;
    logic uses_rs1;
    logic uses_rs2;
    logic has_dest;
    logic illegal;

    // Register fields of the instruction
    dispatch_pkg::areg_t rs1_areg;
    dispatch_pkg::areg_t rs2_areg;
    dispatch_pkg::areg_t rd_areg;
    dispatch_pkg::areg_t src1_areg;
    dispatch_pkg::areg_t src2_areg;

    // Rename results
    dispatch_pkg::preg_t src1_preg;
    dispatch_pkg::preg_t src2_preg;
    logic src1_ready;
    logic src2_ready;
    dispatch_pkg::preg_t old_preg;
    dispatch_pkg::preg_t fl_head_preg;
    logic fl_empty;

    // Retire path from the ROB
    logic commit_en;
    dispatch_pkg::areg_t commit_areg;
    dispatch_pkg::preg_t commit_new_preg;
    dispatch_pkg::preg_t commit_old_preg;
    dispatch_pkg::rob_idx_t rob_tail_idx;

    logic rs_full;
    logic dispatch_en;
    logic dest_valid;
    logic rename_en;

    assign rs1_areg = inst[19:15];
    assign rs2_areg = inst[24:20];
    assign rd_areg = inst[11:7];

    // Unused sources read x0, which is always ready
    assign src1_areg = uses_rs1 ? rs1_areg : '0;
    assign src2_areg = uses_rs2 ? rs2_areg : '0;

    // Stall does not look at inst_valid
    assign stall = rob_full || rs_full || fl_empty;
    assign dispatch_en = inst_valid && !stall && !illegal;

    // Writes to x0 get no physical register
    assign dest_valid = has_dest && (rd_areg != '0);
    assign rename_en = dispatch_en && dest_valid;

    decoder decoder_inst (
        .inst(inst),
        .fu_type(fu_type),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .has_dest(has_dest),
        .illegal(illegal)
    );

    map_table map_table_inst (
        .clock(clock),
        .rst_n(rst_n),
        .src1_areg(src1_areg),
        .src2_areg(src2_areg),
        .dest_areg(rd_areg),
        .rename_en(rename_en),
        .new_preg(fl_head_preg),
        .commit_en(commit_en),
        .commit_areg(commit_areg),
        .commit_preg(commit_new_preg),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .rollback(rollback),
        .src1_preg(src1_preg),
        .src2_preg(src2_preg),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .old_preg(old_preg)
    );

    // Old tag of a committed write returns to the pool
    free_list free_list_inst (
        .clock(clock),
        .rst_n(rst_n),
        .dequeue_en(rename_en),
        .enqueue_en(commit_en),
        .enqueue_preg(commit_old_preg),
        .rollback(rollback),
        .head_preg(fl_head_preg),
        .empty(fl_empty)
    );

    reorder_buffer reorder_buffer_inst (
        .clock(clock),
        .rst_n(rst_n),
        .write_en(dispatch_en),
        .write_areg(rd_areg),
        .write_has_dest(dest_valid),
        .write_new_preg(fl_head_preg),
        .write_old_preg(old_preg),
        .retire(retire),
        .rollback(rollback),
        .tail_idx(rob_tail_idx),
        .head_idx(rob_head_idx),
        .full(rob_full),
        .empty(rob_empty),
        .commit_en(commit_en),
        .commit_areg(commit_areg),
        .commit_new_preg(commit_new_preg),
        .commit_old_preg(commit_old_preg)
    );

    // Stores and x0 writes carry tag 0 as destination
    reservation_station reservation_station_inst (
        .clock(clock),
        .rst_n(rst_n),
        .alloc_en(dispatch_en),
        .alloc_fu(fu_type),
        .alloc_inst(inst),
        .alloc_pc(pc),
        .alloc_src1(src1_preg),
        .alloc_src2(src2_preg),
        .alloc_dest(dest_valid ? fl_head_preg : '0),
        .alloc_src1_ready(src1_ready),
        .alloc_src2_ready(src2_ready),
        .alloc_rob_idx(rob_tail_idx),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .rollback(rollback),
        .full(rs_full),
        .issue_valid(issue_valid),
        .issue_fu(issue_fu),
        .issue_inst(issue_inst),
        .issue_pc(issue_pc),
        .issue_src1(issue_src1),
        .issue_src2(issue_src2),
        .issue_dest(issue_dest),
        .issue_rob_idx(issue_rob_idx)
    );

endmodule

`default_nettype wire

// File: verification/dispatch_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dispatch_macros.svh"

module dispatch_tb;

    // Cycles any single wait may take
    localparam int TIMEOUT = 50;

    logic clock;
    logic rst_n;
    logic inst_valid;
    dispatch_pkg::inst_t inst;
    dispatch_pkg::addr_t pc;
    logic cdb_valid;
    dispatch_pkg::preg_t cdb_tag;
    logic retire;
    logic rollback;
    logic stall;
    logic issue_valid;
    dispatch_pkg::fu_type_t issue_fu;
    dispatch_pkg::inst_t issue_inst;
    dispatch_pkg::addr_t issue_pc;
    dispatch_pkg::preg_t issue_src1;
    dispatch_pkg::preg_t issue_src2;
    dispatch_pkg::preg_t issue_dest;
    dispatch_pkg::rob_idx_t issue_rob_idx;
    dispatch_pkg::rob_idx_t rob_head_idx;
    logic rob_empty;
    logic rob_full;

    int error_count;
    int timeout_count;
    logic [15:0] lfsr;
    logic [31:0] next_pc;

    // Scoreboard state
    int spec_map [`ARCH_REGS];
    int comm_map [`ARCH_REGS];
    int fl_mem [`FREE_LIST_SZ];
    // Free list pointers count modulo twice the depth
    int fl_head;
    int fl_tail;
    // In-flight ROB entries from oldest to youngest
    int rob_areg [$];
    int rob_new [$];
    int rob_old [$];
    int rob_tail;

    dispatch dispatch_inst (
        .clock(clock),
        .rst_n(rst_n),
        .inst_valid(inst_valid),
        .inst(inst),
        .pc(pc),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .retire(retire),
        .rollback(rollback),
        .stall(stall),
        .issue_valid(issue_valid),
        .issue_fu(issue_fu),
        .issue_inst(issue_inst),
        .issue_pc(issue_pc),
        .issue_src1(issue_src1),
        .issue_src2(issue_src2),
        .issue_dest(issue_dest),
        .issue_rob_idx(issue_rob_idx),
        .rob_head_idx(rob_head_idx),
        .rob_empty(rob_empty),
        .rob_full(rob_full)
    );

    // 20 ns period
    always #10 clock = ~clock;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Destination 1 to 31
    function automatic int random_rd();
        int rd;
        rd = int'(lfsr_bits(5));
        if (rd == 0) begin
            rd = 1;
        end
        return rd;
    endfunction

    function automatic logic [31:0] r_type(input int rd, input int rs1, input int rs2);
        return {7'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), `OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), `OPC_OP_IMM};
    endfunction

    // Identity maps and a free list of the upper tags in order
    function automatic void model_reset();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = i;
            comm_map[i] = i;
        end
        for (int i = 0; i < `FREE_LIST_SZ; i++) begin
            fl_mem[i] = `ARCH_REGS + i;
        end
        fl_head = 0;
        fl_tail = `FREE_LIST_SZ;
        rob_tail = 0;
        rob_areg.delete();
        rob_new.delete();
        rob_old.delete();
    endfunction

    function automatic int src_tag(input int areg);
        return (areg == 0) ? 0 : spec_map[areg];
    endfunction

    // Rename of one dispatched instruction
    // rd 0 means no destination
    function automatic void model_dispatch(input int rd, output int new_tag, output int rob_idx);
        int old_tag;
        new_tag = 0;
        old_tag = 0;
        rob_idx = rob_tail;
        if (rd != 0) begin
            new_tag = fl_mem[fl_head % `FREE_LIST_SZ];
            fl_head = (fl_head + 1) % (2 * `FREE_LIST_SZ);
            old_tag = spec_map[rd];
            spec_map[rd] = new_tag;
        end
        rob_areg.push_back(rd);
        rob_new.push_back(new_tag);
        rob_old.push_back(old_tag);
        rob_tail = (rob_tail + 1) % `ROB_SZ;
    endfunction

    // Commit of the oldest entry returns its old tag
    function automatic void model_retire();
        int areg;
        int new_tag;
        int old_tag;
        if (rob_areg.size() == 0) begin
            return;
        end
        areg = rob_areg.pop_front();
        new_tag = rob_new.pop_front();
        old_tag = rob_old.pop_front();
        if (areg != 0) begin
            comm_map[areg] = new_tag;
            fl_mem[fl_tail % `FREE_LIST_SZ] = old_tag;
            fl_tail = (fl_tail + 1) % (2 * `FREE_LIST_SZ);
        end
    endfunction

    function automatic void model_rollback();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_map[i] = comm_map[i];
        end
        rob_areg.delete();
        rob_new.delete();
        rob_old.delete();
        rob_tail = 0;
        // Head jumps a full lap behind the tail
        fl_head = (fl_tail + `FREE_LIST_SZ) % (2 * `FREE_LIST_SZ);
    endfunction

    task automatic check_val(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERROR time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Gave up at time %0t after %0d cycles waiting for %s", $time, TIMEOUT, what);
        timeout_count++;
    endtask

    // Present one instruction and hold it until stall is low at an edge
    task automatic send_inst(input logic [31:0] word, output logic [31:0] addr);
        int waited;
        addr = next_pc;
        next_pc = next_pc + 32'd4;
        @(posedge clock);
        inst_valid <= 1'b1;
        inst <= word;
        pc <= addr;
        waited = 0;
        @(negedge clock);
        while (stall && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            report_timeout("stall to fall");
        end
        // Taken at this edge
        @(posedge clock);
        inst_valid <= 1'b0;
    endtask

    // Wait for the next issue pulse and compare every field
    task automatic expect_issue(input logic [31:0] word, input logic [31:0] addr,
                                input int dest, input int src1, input int src2,
                                input int rob_idx);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!issue_valid && waited < TIMEOUT) begin
            @(negedge clock);
            waited++;
        end
        if (!issue_valid) begin
            report_timeout("issue_valid");
        end else begin
            check_val("issue_fu", int'(issue_fu), int'(dispatch_pkg::ALU));
            check_val("issue_inst", int'(issue_inst), int'(word));
            check_val("issue_pc", int'(issue_pc), int'(addr));
            check_val("issue_dest", int'(issue_dest), dest);
            check_val("issue_src1", int'(issue_src1), src1);
            check_val("issue_src2", int'(issue_src2), src2);
            check_val("issue_rob_idx", int'(issue_rob_idx), rob_idx);
        end
    endtask

    task automatic broadcast(input int tag);
        @(posedge clock);
        cdb_valid <= 1'b1;
        cdb_tag <= 6'(tag);
        @(posedge clock);
        cdb_valid <= 1'b0;
    endtask

    task automatic retire_one();
        @(posedge clock);
        retire <= 1'b1;
        @(posedge clock);
        retire <= 1'b0;
        model_retire();
    endtask

    // An empty ROB has its head back at the tail
    task automatic retire_all();
        int guard;
        guard = 0;
        while (rob_areg.size() > 0 && guard < 2 * `ROB_SZ) begin
            retire_one();
            guard++;
        end
        @(negedge clock);
        check_val("rob_empty", rob_empty, 1);
        check_val("rob_head_idx", int'(rob_head_idx), rob_tail);
    endtask

    task automatic test_reset();
        @(negedge clock);
        check_val("stall", stall, 0);
        check_val("issue_valid", issue_valid, 0);
        check_val("rob_empty", rob_empty, 1);
        check_val("rob_full", rob_full, 0);
        check_val("rob_head_idx", int'(rob_head_idx), 0);
    endtask

    task automatic test_rename_issue();
        int dest;
        int rob_idx;
        int src;
        logic [31:0] word;
        logic [31:0] addr;
        // ADDI x5, x0, imm
        word = i_type(5, 0, int'(lfsr_bits(12)));
        send_inst(word, addr);
        model_dispatch(5, dest, rob_idx);
        expect_issue(word, addr, dest, 0, 0, rob_idx);
        // ADDI result comes back so the consumer can go
        broadcast(dest);
        src = src_tag(5);
        word = r_type(6, 5, 5);
        send_inst(word, addr);
        model_dispatch(6, dest, rob_idx);
        expect_issue(word, addr, dest, src, src, rob_idx);
    endtask

    task automatic test_wakeup();
        int dest;
        int rob_idx;
        int src;
        logic [31:0] word;
        logic [31:0] addr;
        // Producer of x6 has not broadcast yet
        src = src_tag(6);
        word = r_type(7, 6, 0);
        send_inst(word, addr);
        model_dispatch(7, dest, rob_idx);
        repeat (10) begin
            @(negedge clock);
            if (issue_valid) begin
                $display("Chained ADD issued before tag %0d was broadcast", src);
                error_count++;
            end
        end
        broadcast(src);
        expect_issue(word, addr, dest, src, 0, rob_idx);
    endtask

    task automatic test_backpressure();
        int dest;
        int rob_idx;
        int rd;
        logic [31:0] word;
        logic [31:0] addr;
        retire_all();
        for (int i = 0; i < `ROB_SZ; i++) begin
            rd = random_rd();
            word = i_type(rd, 0, int'(lfsr_bits(12)));
            send_inst(word, addr);
            model_dispatch(rd, dest, rob_idx);
            expect_issue(word, addr, dest, 0, 0, rob_idx);
        end
        @(negedge clock);
        check_val("stall", stall, 1);
        check_val("rob_full", rob_full, 1);
        // Ninth instruction held by fetch
        rd = random_rd();
        word = i_type(rd, 0, int'(lfsr_bits(12)));
        addr = next_pc;
        next_pc = next_pc + 32'd4;
        @(posedge clock);
        inst_valid <= 1'b1;
        inst <= word;
        pc <= addr;
        repeat (10) begin
            @(negedge clock);
            if (!stall || issue_valid) begin
                $display("Held instruction went ahead while the ROB was full");
                error_count++;
            end
        end
        retire_one();
        @(negedge clock);
        check_val("stall", stall, 0);
        // Dispatches at this edge
        @(posedge clock);
        inst_valid <= 1'b0;
        model_dispatch(rd, dest, rob_idx);
        expect_issue(word, addr, dest, 0, 0, rob_idx);
    endtask

    task automatic test_recycle();
        int dest;
        int rob_idx;
        int rd;
        int recycled;
        logic [31:0] word;
        logic [31:0] addr;
        retire_all();
        recycled = 0;
        for (int i = 0; i < 16; i++) begin
            rd = random_rd();
            word = i_type(rd, 0, int'(lfsr_bits(12)));
            send_inst(word, addr);
            model_dispatch(rd, dest, rob_idx);
            expect_issue(word, addr, dest, 0, 0, rob_idx);
            // Tags below the architectural count only come back through retire
            if (issue_valid && int'(issue_dest) < `ARCH_REGS) begin
                recycled++;
            end
            retire_one();
        end
        if (recycled == 0) begin
            $display("No returned tag was handed out again in 16 dispatches");
            error_count++;
        end
    endtask

    task automatic test_rollback_illegal();
        int dest;
        int rob_idx;
        int rd_a;
        int rd_b;
        int src1;
        int src2;
        logic [31:0] word;
        logic [31:0] addr;
        retire_all();
        // Speculative writes that rollback must undo
        rd_a = random_rd();
        rd_b = random_rd();
        word = i_type(rd_a, 0, int'(lfsr_bits(12)));
        send_inst(word, addr);
        model_dispatch(rd_a, dest, rob_idx);
        expect_issue(word, addr, dest, 0, 0, rob_idx);
        word = i_type(rd_b, 0, int'(lfsr_bits(12)));
        send_inst(word, addr);
        model_dispatch(rd_b, dest, rob_idx);
        expect_issue(word, addr, dest, 0, 0, rob_idx);
        @(posedge clock);
        rollback <= 1'b1;
        @(posedge clock);
        rollback <= 1'b0;
        model_rollback();
        @(negedge clock);
        check_val("rob_empty", rob_empty, 1);
        // Sources now come from the committed map
        src1 = src_tag(rd_a);
        src2 = src_tag(rd_b);
        word = r_type(rd_a, rd_a, rd_b);
        send_inst(word, addr);
        model_dispatch(rd_a, dest, rob_idx);
        expect_issue(word, addr, dest, src1, src2, rob_idx);
        retire_all();
        // Branch opcode is outside the decoded classes
        word = {20'h0, 5'd9, 7'b1100011};
        send_inst(word, addr);
        repeat (10) begin
            @(negedge clock);
            if (issue_valid || !rob_empty) begin
                $display("Illegal instruction at pc 0x%0h was dispatched", addr);
                error_count++;
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        pc = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        retire = 1'b0;
        rollback = 1'b0;
        error_count = 0;
        timeout_count = 0;
        lfsr = 16'd44249;
        next_pc = 32'h0000_1000;
        model_reset();
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        test_reset();
        test_rename_issue();
        test_wakeup();
        test_backpressure();
        test_recycle();
        test_rollback_illegal();
        $display("Run finished: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
rtl/dispatch_pkg.sv
rtl/decoder.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/reservation_station.sv
rtl/dispatch.sv
verification/dispatch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dispatch_tb -f tb.f -o dispatch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/dispatch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
